/* nes_dma_bus.f */
rtl/nes_bus_pkg.sv
rtl/dma_master_if.sv
rtl/clock_enable_gen.sv
rtl/dma_controller.sv
rtl/cpu_bus_unit.sv
rtl/nes_dma_bus.sv
sim/nes_dma_bus_asserts.sv
sim/tb_nes_dma_bus.sv

/* rtl/clock_enable_gen.sv */
`timescale 1ns/1ps

// Master clock divider for the CPU enable
// Cycle layout: counter runs 1..CPU_DIV and cpu_ce fires on the last count,
// PAL holds one cycle in five for an extra clock
module clock_enable_gen import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] sys_type,     // Region select
	output logic       cpu_ce,       // One clock per CPU cycle
	output logic       get_ce,       // cpu_ce ending a get (even) cycle
	output logic       put_ce,       // cpu_ce ending a put (odd) cycle
	output logic       put_cycle     // Level, 1 during a put cycle
);

	logic [CPU_DIV_W-1:0] div_cnt;          // Master clocks into this CPU cycle
	logic [CPU_DIV_W-1:0] div_end;          // Count that closes this CPU cycle
	logic [PAL_CNT_W-1:0] pal_cnt;          // Position inside the PAL stretch window
	logic                 pal_last;         // Last cycle of the window
	logic                 stretch;          // This cycle runs CPU_DIV+1 clocks
	logic [1:0]           last_sys_type;    // For realignment on a region change

	assign pal_last = (pal_cnt == PAL_CNT_W'(PAL_STRETCH_PERIOD - 1));
	assign stretch  = (sys_type == SYS_PAL) && pal_last;
	assign div_end  = stretch ? CPU_DIV_W'(CPU_DIV + 1) : CPU_DIV_W'(CPU_DIV);

	assign cpu_ce = (div_cnt == div_end);
	assign get_ce = cpu_ce && !put_cycle;
	assign put_ce = cpu_ce && put_cycle;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt       <= CPU_DIV_W'(1);
			pal_cnt       <= '0;
			put_cycle     <= 1'b1;         // First cycle after reset is a put
			last_sys_type <= sys_type;
		end else begin
			last_sys_type <= sys_type;
			div_cnt       <= cpu_ce ? CPU_DIV_W'(1) : div_cnt + 1'b1;

			if (cpu_ce) begin
				put_cycle <= !put_cycle;    // Get and put alternate every CPU cycle
				// Window only advances while running PAL
				if (sys_type == SYS_PAL)
					pal_cnt <= pal_last ? '0 : pal_cnt + 1'b1;
			end

			// Region switch restarts the divider, overrides the counts above
			if (last_sys_type != sys_type) begin
				div_cnt <= CPU_DIV_W'(1);
				pal_cnt <= '0;
			end
		end
	end

endmodule

/* rtl/cpu_bus_unit.sv */
`timescale 1ns/1ps

// Outgoing bus mux between CPU and DMA, joypad port, incoming data with open bus
module cpu_bus_unit import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cpu_ce,
	input  logic       put_ce,
	input  addr_t      cpu_addr,
	input  logic       cpu_rnw,
	input  data_t      cpu_dout,
	dma_master_if.bus  dma,
	input  data_t      mem_din,         // Byte from external memory
	input  logic       mem_drive,       // External memory drives the bus
	input  logic [4:0] joypad1_data,
	input  logic [4:0] joypad2_data,
	output addr_t      bus_addr,
	output logic       bus_read,
	output logic       bus_write,
	output data_t      bus_dout,
	output data_t      cpu_din,         // Byte seen by CPU and DMA
	output logic [2:0] joypad_out,      // Strobe bits toward the pads
	output logic [1:0] joypad_clock     // Per port, high on a read of its register
);

	logic       apu_sel;          // $4000-$401F block
	logic       joy1_sel;
	logic       joy2_sel;
	logic       joy_strobe_wr;    // Write to $4016 this cycle
	logic [2:0] joy_latch;        // Strobe value waiting for a put cycle
	data_t      open_bus;         // Last value driven on the data bus

	// DMA takes over address, direction and write data
	assign bus_addr  = dma.aout_enable ? dma.aout : cpu_addr;
	assign bus_read  = dma.aout_enable ? dma.read : cpu_rnw;
	assign bus_write = dma.aout_enable ? !dma.read : !cpu_rnw;
	assign bus_dout  = dma.aout_enable ? dma.wdata : cpu_dout;

	// Decode on the muxed address, so a DMA read of $4016 clocks the pad too
	assign apu_sel  = (bus_addr[15:5] == APU_PAGE);
	assign joy1_sel = apu_sel && (bus_addr[4:0] == JOY1_REG[4:0]);
	assign joy2_sel = apu_sel && (bus_addr[4:0] == JOY2_REG[4:0]);

	assign joypad_clock  = {joy2_sel && bus_read, joy1_sel && bus_read};
	assign joy_strobe_wr = joy1_sel && bus_write;

	// Pads drive only D4-D0, upper bits float at the open bus value
	always_comb begin
		if (joypad_clock[0])
			cpu_din = {open_bus[7:5], joypad1_data};
		else if (joypad_clock[1])
			cpu_din = {open_bus[7:5], joypad2_data};
		else if (mem_drive)
			cpu_din = mem_din;
		else
			cpu_din = open_bus;    // Nothing drives the bus, keep last value
	end

	// Strobe reaches the pads only on put cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			joy_latch  <= '0;
			joypad_out <= '0;
		end else begin
			if (cpu_ce && joy_strobe_wr)
				joy_latch <= bus_dout[2:0];
			if (put_ce)
				joypad_out <= joy_strobe_wr ? bus_dout[2:0] : joy_latch;    // Bypass a write
		end
	end

	// Bus capacitance model, skips the clock where the next cycle takes over
	always_ff @(posedge clk) begin
		if (!cpu_ce)
			open_bus <= bus_write ? bus_dout : cpu_din;
	end

endmodule

/* rtl/dma_controller.sv */
`timescale 1ns/1ps

// Sprite DMA and DMC sample fetch
// Sprite: read page byte on a get cycle, write it to $2004 on the following put cycle
// DMC: armed at a put_ce, owns the next get cycle, sprite DMA backs off around it
module dma_controller import nes_bus_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  cpu_ce,
	input  logic  get_ce,
	input  logic  put_ce,
	input  logic  put_cycle,
	input  addr_t cpu_addr,
	input  logic  cpu_rnw,
	input  data_t cpu_dout,
	input  data_t cpu_din,        // Read data from the bus unit
	input  logic  dmc_request,
	input  addr_t dmc_addr,
	output logic  dmc_ack,
	output logic  pause_cpu,
	dma_master_if.master dma
);

	typedef enum logic [1:0] {
		SPR_IDLE,
		SPR_ALIGN,     // CPU halted, waiting for a get cycle to begin
		SPR_ACTIVE     // Transfer running
	} spr_state_t;

	spr_state_t spr_state;
	logic       dmc_busy;         // DMC fetch pending or in progress
	logic [7:0] spr_offset;       // Low address byte of the next sprite read
	logic [7:0] spr_page;         // High address byte from the $4014 write
	data_t      spr_data;         // Byte read on the last sprite get cycle
	logic       spr_trigger;
	logic       dmc_slot;         // Get cycle taken by the DMC
	logic       spr_bus;          // Sprite DMA drives the bus this cycle

	assign spr_trigger = (cpu_addr == OAM_DMA_REG) && !cpu_rnw;
	assign dmc_slot    = dmc_busy && !put_cycle;
	assign spr_bus     = (spr_state == SPR_ACTIVE) && !dmc_slot;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state  <= SPR_IDLE;
			dmc_busy   <= 1'b0;
			spr_offset <= '0;
		end else if (cpu_ce) begin
			// DMC arms only while the CPU is reading, clears after its get cycle
			if (!dmc_busy && dmc_request && cpu_rnw && put_ce)
				dmc_busy <= 1'b1;
			else if (dmc_busy && put_ce)
				dmc_busy <= 1'b0;

			if (spr_trigger) begin
				spr_state  <= SPR_ALIGN;
				spr_offset <= '0;
			end else begin
				case (spr_state)
					SPR_ALIGN: begin
						if (put_ce && cpu_rnw)
							spr_state <= SPR_ACTIVE;    // Next cycle is a get
					end
					SPR_ACTIVE: begin
						if (get_ce && dmc_slot)
							spr_state <= SPR_ALIGN;     // Stolen get, idle put follows
						else if (put_ce && spr_offset == 8'h00)
							spr_state <= SPR_IDLE;      // Offset wrapped, last write done
						else if (get_ce)
							spr_offset <= spr_offset + 8'd1;
					end
					default: ;
				endcase
			end
		end
	end

	// Source page and last sprite read byte
	always_ff @(posedge clk) begin
		if (cpu_ce && spr_trigger)
			spr_page <= cpu_dout;
		if (get_ce && spr_bus)
			spr_data <= cpu_din;    // Byte for the next $2004 write
	end

	// DMC holds the CPU from request through its trailing put cycle
	assign pause_cpu = (spr_state != SPR_IDLE) || dmc_request || dmc_busy;
	assign dmc_ack   = dmc_slot && dmc_request;    // Drops early if the requester lets go

	assign dma.aout_enable = dmc_ack || spr_bus;
	assign dma.read        = !put_cycle;           // Reads on get, writes on put
	assign dma.wdata       = spr_data;
	assign dma.aout        = dmc_ack ? dmc_addr :
		!put_cycle ? {spr_page, spr_offset} : OAM_DATA_REG;

endmodule

/* rtl/dma_master_if.sv */
`timescale 1ns/1ps

// Bus request from the DMA controller toward the bus unit
// Plain levels, valid for the whole CPU cycle and taken at cpu_ce
interface dma_master_if import nes_bus_pkg::*; ();

	addr_t aout;           // Address of the DMA access
	logic  aout_enable;    // DMA owns the bus this cycle
	logic  read;           // 1 = read, 0 = write
	data_t wdata;          // Byte for a DMA write

	modport master (
		output aout,
		output aout_enable,
		output read,
		output wdata
	);

	modport bus (
		input aout,
		input aout_enable,
		input read,
		input wdata
	);

endinterface

/* rtl/nes_bus_pkg.sv */
package nes_bus_pkg;

	// CPU side bus types
	typedef logic [15:0] addr_t;    // 6502 address bus
	typedef logic [7:0]  data_t;    // 6502 data bus

	// Master clock divider
	localparam int CPU_DIV            = 12;    // Master clocks per CPU cycle
	localparam int PAL_STRETCH_PERIOD = 5;     // PAL adds one clock to every fifth CPU cycle
	localparam int CPU_DIV_W          = $clog2(CPU_DIV + 2);    // Room for the stretched count
	localparam int PAL_CNT_W          = $clog2(PAL_STRETCH_PERIOD);

	// Region code on sys_type
	localparam logic [1:0] SYS_PAL = 2'b01;

	// Register map seen by the DMA and joypad logic
	localparam addr_t OAM_DMA_REG  = 16'h4014;    // Sprite DMA page register
	localparam addr_t OAM_DATA_REG = 16'h2004;    // PPU OAM data port
	localparam addr_t JOY1_REG     = 16'h4016;    // Joypad strobe on write, port 1 on read
	localparam addr_t JOY2_REG     = 16'h4017;    // Port 2 on read

	// A[15:5] of the $4000-$401F block inside the CPU chip
	localparam logic [10:0] APU_PAGE = 11'b0100_0000_000;

endpackage

/* rtl/nes_dma_bus.sv */
`timescale 1ns/1ps

// Bus side of the CPU chip: clock enables, sprite/DMC DMA and bus unit
module nes_dma_bus import nes_bus_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] sys_type,
	input  addr_t      cpu_addr,
	input  logic       cpu_rnw,
	input  data_t      cpu_dout,
	input  logic       dmc_request,
	input  addr_t      dmc_addr,
	input  data_t      mem_din,
	input  logic       mem_drive,
	input  logic [4:0] joypad1_data,
	input  logic [4:0] joypad2_data,
	output logic       cpu_ce,
	output logic       pause_cpu,
	output logic       dmc_ack,
	output addr_t      bus_addr,
	output logic       bus_read,
	output logic       bus_write,
	output data_t      bus_dout,
	output data_t      cpu_din,
	output logic [2:0] joypad_out,
	output logic [1:0] joypad_clock
);

	logic get_ce;
	logic put_ce;
	logic put_cycle;

	dma_master_if dma_bus ();    // DMA request toward the bus mux

	clock_enable_gen u_clock_enable_gen (
		.clk       (clk),
		.reset     (reset),
		.sys_type  (sys_type),
		.cpu_ce    (cpu_ce),
		.get_ce    (get_ce),
		.put_ce    (put_ce),
		.put_cycle (put_cycle)
	);

	dma_controller u_dma_controller (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.get_ce      (get_ce),
		.put_ce      (put_ce),
		.put_cycle   (put_cycle),
		.cpu_addr    (cpu_addr),
		.cpu_rnw     (cpu_rnw),
		.cpu_dout    (cpu_dout),
		.cpu_din     (cpu_din),       // Sprite DMA latches the bus read data
		.dmc_request (dmc_request),
		.dmc_addr    (dmc_addr),
		.dmc_ack     (dmc_ack),
		.pause_cpu   (pause_cpu),
		.dma         (dma_bus.master)
	);

	cpu_bus_unit u_cpu_bus_unit (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.put_ce       (put_ce),
		.cpu_addr     (cpu_addr),
		.cpu_rnw      (cpu_rnw),
		.cpu_dout     (cpu_dout),
		.dma          (dma_bus.bus),
		.mem_din      (mem_din),
		.mem_drive    (mem_drive),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.bus_addr     (bus_addr),
		.bus_read     (bus_read),
		.bus_write    (bus_write),
		.bus_dout     (bus_dout),
		.cpu_din      (cpu_din),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the nes_dma_bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tb_nes_dma_bus \
	-f nes_dma_bus.f \
	-o sim_nes_dma_bus

./obj_dir/sim_nes_dma_bus +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

/* sim/nes_dma_bus_asserts.sv */
`timescale 1ns/1ps

// Bus protocol properties of the bus unit
module nes_dma_bus_asserts import nes_bus_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       cpu_ce,
	input logic       put_ce,
	input logic       dma_aout_enable,
	input logic       dma_read,
	input addr_t      dma_aout,
	input logic [2:0] joypad_out
);

	int fail_count = 0;    // Failed assertions so far

	// DMA reads on get cycles and writes on put cycles
	dma_cycle_direction: assert property (@(posedge clk) disable iff (reset)
		(cpu_ce && dma_aout_enable) |-> (dma_read == !put_ce))
	else begin
		fail_count++;
		$error("DMA access direction does not match the get/put cycle");
	end

	// Sprite DMA writes land only on the OAM data port
	dma_write_target: assert property (@(posedge clk) disable iff (reset)
		(dma_aout_enable && !dma_read) |-> (dma_aout == OAM_DATA_REG))
	else begin
		fail_count++;
		$error("DMA write to an address other than $2004");
	end

	// Pad strobe outputs move only after a put cycle
	joypad_out_on_put: assert property (@(posedge clk) disable iff (reset)
		!$stable(joypad_out) |-> $past(put_ce))
	else begin
		fail_count++;
		$error("joypad_out changed outside a put cycle");
	end

endmodule

bind cpu_bus_unit nes_dma_bus_asserts bus_asserts (
	.clk             (clk),
	.reset           (reset),
	.cpu_ce          (cpu_ce),
	.put_ce          (put_ce),
	.dma_aout_enable (dma.aout_enable),
	.dma_read        (dma.read),
	.dma_aout        (dma.aout),
	.joypad_out      (joypad_out)
);

/* sim/tb_nes_dma_bus.sv */
`timescale 1ns/1ps

// Directed testbench, plays the CPU, the memory and the DMC requester
module tb_nes_dma_bus import nes_bus_pkg::*; ();

	// Nominal CPU cycles: two sprite DMAs, three period runs, the rest
	localparam int SPRITE_DMA_CYCLES = 520;
	localparam int PERIOD_CYCLES     = 60;
	localparam int OTHER_CYCLES      = 40;
	localparam int NOMINAL_CYCLES    = 2 * SPRITE_DMA_CYCLES + PERIOD_CYCLES + OTHER_CYCLES;
	localparam int TIMEOUT_CLOCKS    = 4 * NOMINAL_CYCLES * (CPU_DIV + 1);

	logic       clk;
	logic       reset;
	logic [1:0] sys_type;
	addr_t      cpu_addr;
	logic       cpu_rnw;
	data_t      cpu_dout;
	logic       dmc_request;
	addr_t      dmc_addr;
	data_t      mem_din;
	logic       mem_drive;
	logic [4:0] joypad1_data;
	logic [4:0] joypad2_data;
	logic       cpu_ce;
	logic       pause_cpu;
	logic       dmc_ack;
	addr_t      bus_addr;
	logic       bus_read;
	logic       bus_write;
	data_t      bus_dout;
	data_t      cpu_din;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	logic [31:0] rng = 32'd2510;    // xorshift state
	int          clk_count = 0;
	data_t       last_din;          // cpu_din at the end of the last CPU cycle
	logic [1:0]  last_jclk;         // joypad_clock at the end of the last CPU cycle

	nes_dma_bus dut (.*);

	// RAM below $2000, byte is low address XOR high address
	assign mem_drive = (bus_addr < 16'h2000);
	assign mem_din   = bus_addr[7:0] ^ bus_addr[15:8];

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		clk_count <= clk_count + 1;
		if (clk_count >= TIMEOUT_CLOCKS) begin
			$display("Timeout: tests did not complete within %0d clocks", TIMEOUT_CLOCKS);
			$display("Result: FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Stops at the falling edge inside the last clock of a CPU cycle
	task automatic wait_cpu_ce();
		do begin
			@(negedge clk);
		end while (!cpu_ce);
	endtask

	// One CPU access, called and returning at the first falling edge of a cycle
	task automatic cpu_cycle(input addr_t addr, input logic rnw, input data_t dout);
		check_equal(16'(pause_cpu), 16'd0, "CPU access while paused");
		cpu_addr = addr;
		cpu_rnw  = rnw;
		cpu_dout = dout;
		wait_cpu_ce();
		last_din  = cpu_din;
		last_jclk = joypad_clock;
		@(negedge clk);
	endtask

	task automatic ce_period_test(input logic [1:0] region, input int n_periods);
		int periods[$];
		int clocks;
		int longs;
		sys_type = region;
		wait_cpu_ce();    // Cycle cut by the realignment
		wait_cpu_ce();
		for (int i = 0; i < n_periods; i++) begin
			clocks = 0;
			do begin
				@(negedge clk);
				clocks++;
			end while (!cpu_ce);
			periods.push_back(clocks);
		end
		@(negedge clk);
		if (region == SYS_PAL) begin
			foreach (periods[i])
				check_equal(16'(periods[i] == CPU_DIV || periods[i] == CPU_DIV + 1), 16'd1,
					"PAL period length");
			// Sliding window of PAL_STRETCH_PERIOD periods
			for (int i = 0; i + PAL_STRETCH_PERIOD <= n_periods; i++) begin
				longs = 0;
				for (int j = i; j < i + PAL_STRETCH_PERIOD; j++)
					if (periods[j] == CPU_DIV + 1)
						longs++;
				check_equal(16'(longs), 16'd1, "stretched periods per PAL window");
			end
		end else begin
			foreach (periods[i])
				check_equal(16'(periods[i]), 16'(CPU_DIV), "NTSC period length");
		end
	endtask

	task automatic sprite_dma_test(input logic [7:0] page, input logic with_dmc);
		int    reads;
		int    writes;
		int    acks;
		data_t read_byte;
		logic  busy;
		logic  dmc_sent;
		reads     = 0;
		writes    = 0;
		acks      = 0;
		read_byte = '0;
		dmc_sent  = 1'b0;
		cpu_cycle(OAM_DMA_REG, 1'b0, page);
		check_equal(16'(pause_cpu), 16'd1, "pause_cpu after the $4014 write");
		cpu_rnw = 1'b1;    // Halted CPU holds its address as a read
		do begin
			wait_cpu_ce();
			if (dmc_ack) begin
				check_equal(bus_addr, dmc_addr, "DMC address inside sprite DMA");
				check_equal(16'(bus_read), 16'd1, "DMC fetch direction");
				acks++;
			end else if (bus_read && bus_addr[15:8] == page) begin
				check_equal(16'(bus_addr[7:0]), 16'(reads[7:0]), "sprite read offset");
				read_byte = page ^ reads[7:0];
				check_equal(16'(cpu_din), 16'(read_byte), "sprite read data");
				reads++;
			end else if (bus_write) begin
				check_equal(bus_addr, OAM_DATA_REG, "sprite write address");
				check_equal(16'(bus_dout), 16'(read_byte), "sprite write data");
				writes++;
			end
			@(negedge clk);
			busy = pause_cpu;
			if (acks != 0) begin
				dmc_request = 1'b0;    // Acknowledged cycle is over
			end else if (with_dmc && !dmc_sent && reads == 100) begin
				rng         = xorshift(rng);
				dmc_addr    = 16'hC000 | {2'b00, rng[13:0]};
				dmc_request = 1'b1;
				dmc_sent    = 1'b1;
			end
		end while (busy);
		check_equal(16'(reads), 16'd256, "sprite read count");
		check_equal(16'(writes), 16'd256, "sprite write count");
		check_equal(16'(acks), 16'(with_dmc), "DMC fetches inside sprite DMA");
	endtask

	task automatic dmc_fetch_test();
		int   acks;
		logic busy;
		acks = 0;
		cpu_cycle(16'h0123, 1'b1, 8'h00);
		rng         = xorshift(rng);
		dmc_addr    = 16'hC000 | {2'b00, rng[13:0]};
		dmc_request = 1'b1;    // CPU keeps reading $0123
		do begin
			wait_cpu_ce();
			check_equal(16'(pause_cpu), 16'd1, "pause_cpu during DMC fetch");
			if (dmc_ack) begin
				check_equal(bus_addr, dmc_addr, "DMC fetch address");
				check_equal(16'(bus_read), 16'd1, "DMC fetch direction");
				acks++;
			end
			@(negedge clk);
			busy = pause_cpu;
			if (acks != 0)
				dmc_request = 1'b0;
		end while (busy);
		check_equal(16'(acks), 16'd1, "dmc_ack cycles");
	endtask

	task automatic joypad_test();
		data_t strobe;
		rng          = xorshift(rng);
		strobe       = rng[7:0];
		rng          = xorshift(rng);
		joypad1_data = rng[4:0];
		joypad2_data = rng[12:8];
		cpu_cycle(JOY1_REG, 1'b0, strobe);
		check_equal(16'(last_jclk), 16'd0, "joypad_clock on $4016 write");
		cpu_cycle(JOY1_REG, 1'b1, 8'h00);
		check_equal(16'(last_jclk), 16'b01, "joypad_clock on $4016 read");
		check_equal(16'(last_din), 16'({strobe[7:5], joypad1_data}), "$4016 read data");
		check_equal(16'(joypad_out), 16'(strobe[2:0]), "joypad_out after strobe write");
		cpu_cycle(JOY2_REG, 1'b1, 8'h00);
		check_equal(16'(last_jclk), 16'b10, "joypad_clock on $4017 read");
		check_equal(16'(last_din), 16'({strobe[7:5], joypad2_data}), "$4017 read data");
	endtask

	task automatic open_bus_test();
		data_t value;
		rng   = xorshift(rng);
		value = rng[7:0];
		cpu_cycle(16'h5000, 1'b0, value);    // Nothing decodes $5000
		cpu_cycle(16'h6000, 1'b1, 8'h00);
		check_equal(16'(last_din), 16'(value), "open bus after a write");
		cpu_cycle(16'h0155, 1'b1, 8'h00);
		check_equal(16'(last_din), 16'h54, "RAM read data");
		cpu_cycle(16'h7000, 1'b1, 8'h00);
		check_equal(16'(last_din), 16'h54, "open bus after a read");
	endtask

	initial begin
		reset        = 1'b1;
		sys_type     = 2'b00;
		cpu_addr     = 16'h0000;
		cpu_rnw      = 1'b1;
		cpu_dout     = 8'h00;
		dmc_request  = 1'b0;
		dmc_addr     = 16'hC000;
		joypad1_data = 5'd0;
		joypad2_data = 5'd0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		ce_period_test(2'b00, 20);
		ce_period_test(SYS_PAL, 15);
		ce_period_test(2'b00, 5);     // Back to NTSC for the rest
		sprite_dma_test(8'h03, 1'b0);
		dmc_fetch_test();
		sprite_dma_test(8'h07, 1'b1);
		joypad_test();
		open_bus_test();

		if (dut.u_cpu_bus_unit.bus_asserts.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Bus protocol assertions failed during the run");
			$display("Result: FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule
